//--- source/sdt_storage_pkg.sv
// storage block layout for the autotest sequencer
// block size, start address and valid-block signature
// record length and result block field offsets

`default_nettype none

package sdt_storage_pkg;

  localparam int unsigned BLOCK_BYTES  = 64;
  localparam int unsigned BYTE_CNT_W   = $clog2(BLOCK_BYTES);
  localparam int unsigned BLOCK_ADDR_W = 32;
  localparam logic [BLOCK_ADDR_W-1:0] START_BLOCK = 32'h0010_0000;
  localparam logic [31:0] SIGNATURE = 32'hAABB_CCDD;

  // test record at the head of every read block
  localparam int unsigned RECORD_BYTES = 16;
  localparam int unsigned RECORD_IDX_W = $clog2(RECORD_BYTES);

  // result block offsets with zero bytes after the status
  localparam int unsigned RES_RESULT_OFS = 16;
  localparam int unsigned RES_CYCLES_OFS = 20;
  localparam int unsigned RES_STATUS_OFS = 24;

endpackage

`default_nettype wire

//--- source/sdt_test_pkg.sv
// test side definitions for the autotest sequencer
// operand, result, cycle and counter widths
// timeout limit and status byte bit positions
// test record union with byte and field views

`default_nettype none

package sdt_test_pkg;

  import sdt_storage_pkg::*;

  localparam int unsigned OPERAND_W = 32;
  localparam int unsigned RESULT_W  = 32;
  localparam int unsigned CYCLES_W  = 32;
  localparam int unsigned COUNT_W   = 32;
  localparam int unsigned STATUS_W  = 8;

  localparam logic [CYCLES_W-1:0] TIMEOUT_CYCLES = 32'd200;

  localparam int unsigned STATUS_MISMATCH_BIT = 0;
  localparam int unsigned STATUS_TIMEOUT_BIT  = 1;

  // byte 0 is the first byte on the bus and the msb of the record
  typedef union packed {
    logic [0:RECORD_BYTES-1][7:0] bytes;
    struct packed {
      logic [31:0]          signature;
      logic [OPERAND_W-1:0] operand_a;
      logic [OPERAND_W-1:0] operand_b;
      logic [RESULT_W-1:0]  expected;
    } fields;
  } test_record_u;

endpackage

`default_nettype wire

//--- source/sdt_control.sv
// sequencing FSM of the autotest run
// block address register, read and write requests,
// UUT reset control and strobes to the datapath

`timescale 1ns/1ps
`default_nettype none

module sdt_control
  import sdt_storage_pkg::*;
  import sdt_test_pkg::*;
(
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     start_i,
  input  wire                     rd_gnt_i,
  input  wire                     wr_gnt_i,
  input  wire                     load_done_i,
  input  wire  test_record_u      record_i,
  input  wire                     run_end_i,
  input  wire                     write_done_i,
  output logic                    rd_req_o,
  output logic                    wr_req_o,
  output logic [BLOCK_ADDR_W-1:0] blk_addr_o,
  output logic                    uut_rst_o,
  output logic                    load_start_o,
  output logic                    run_start_o,
  output logic                    check_en_o,
  output logic                    write_start_o,
  output logic                    busy_o,
  output logic                    run_done_o
);

  localparam logic [3:0] S_IDLE    = 4'd0;
  localparam logic [3:0] S_RD_REQ  = 4'd1;
  localparam logic [3:0] S_LOAD    = 4'd2;
  localparam logic [3:0] S_SIG     = 4'd3;
  localparam logic [3:0] S_RUN     = 4'd4;
  localparam logic [3:0] S_CHECK   = 4'd5;
  localparam logic [3:0] S_WR_REQ  = 4'd6;
  localparam logic [3:0] S_WRITE   = 4'd7;
  localparam logic [3:0] S_NEXT    = 4'd8;

  logic [3:0] state_q;
  logic [3:0] state_d;
  logic       sig_ok;

  assign sig_ok = (record_i.fields.signature == SIGNATURE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= S_IDLE;
      blk_addr_o <= START_BLOCK;
    end else begin
      state_q <= state_d;
      if (state_q == S_IDLE && start_i) begin
        blk_addr_o <= START_BLOCK;
      end else if (state_q == S_NEXT) begin
        blk_addr_o <= blk_addr_o + 1'b1;
      end
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:   if (start_i) state_d = S_RD_REQ;
      S_RD_REQ: if (rd_gnt_i) state_d = S_LOAD;
      S_LOAD:   if (load_done_i) state_d = S_SIG;
      // bad signature ends the run without a write-back
      S_SIG:    state_d = sig_ok ? S_RUN : S_IDLE;
      S_RUN:    if (run_end_i) state_d = S_CHECK;
      S_CHECK:  state_d = S_WR_REQ;
      S_WR_REQ: if (wr_gnt_i) state_d = S_WRITE;
      S_WRITE:  if (write_done_i) state_d = S_NEXT;
      S_NEXT:   state_d = S_RD_REQ;
      default:  state_d = S_IDLE;
    endcase
  end

  assign rd_req_o      = (state_q == S_RD_REQ);
  assign wr_req_o      = (state_q == S_WR_REQ);
  assign uut_rst_o     = (state_q != S_RUN);
  assign load_start_o  = (state_q == S_RD_REQ) && rd_gnt_i;
  assign run_start_o   = (state_q == S_SIG) && sig_ok;
  // result sampled while the UUT is still out of reset
  assign check_en_o    = (state_q == S_RUN) && run_end_i;
  assign write_start_o = (state_q == S_WR_REQ) && wr_gnt_i;
  assign busy_o        = (state_q != S_IDLE);
  assign run_done_o    = (state_q == S_SIG) && !sig_ok;

endmodule

`default_nettype wire

//--- source/sdt_record_loader.sv
// read block receiver
// takes the block byte by byte over valid/ready,
// keeps the leading test record and drops the rest

`timescale 1ns/1ps
`default_nettype none

module sdt_record_loader
  import sdt_storage_pkg::*;
  import sdt_test_pkg::*;
(
  input  wire          clk,
  input  wire          rst,
  input  wire          load_start_i,
  input  wire  [7:0]   rd_data_i,
  input  wire          rd_valid_i,
  output logic         rd_ready_o,
  output logic         load_done_o,
  output test_record_u record_o
);

  logic [BYTE_CNT_W-1:0] byte_cnt;
  logic                  byte_take;

  assign byte_take = rd_ready_o && rd_valid_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ready_o  <= 1'b0;
      load_done_o <= 1'b0;
      byte_cnt    <= '0;
    end else begin
      load_done_o <= 1'b0;
      if (load_start_i) begin
        rd_ready_o <= 1'b1;
        byte_cnt   <= '0;
      end else if (byte_take) begin
        byte_cnt <= byte_cnt + 1'b1;
        if (byte_cnt == BYTE_CNT_W'(BLOCK_BYTES - 1)) begin
          rd_ready_o  <= 1'b0;
          load_done_o <= 1'b1;
        end
      end
    end
  end

  // filler past the record is consumed only
  always_ff @(posedge clk) begin
    if (byte_take && byte_cnt < RECORD_BYTES) begin
      record_o.bytes[byte_cnt[RECORD_IDX_W-1:0]] <= rd_data_i;
    end
  end

endmodule

`default_nettype wire

//--- source/sdt_exec_timer.sv
// UUT execution timer
// counts run cycles until done or timeout,
// saturating at the timeout limit

`timescale 1ns/1ps
`default_nettype none

module sdt_exec_timer
  import sdt_test_pkg::*;
(
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 run_start_i,
  input  wire                 uut_running_i,
  input  wire                 uut_done_i,
  output logic                run_end_o,
  output logic [CYCLES_W-1:0] exec_cycles_o,
  output logic                timed_out_o
);

  logic active_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      active_q      <= 1'b0;
      run_end_o     <= 1'b0;
      exec_cycles_o <= '0;
      timed_out_o   <= 1'b0;
    end else begin
      run_end_o <= 1'b0;
      if (run_start_i) begin
        active_q      <= 1'b1;
        exec_cycles_o <= '0;
        timed_out_o   <= 1'b0;
      end else if (active_q && uut_running_i) begin
        if (uut_done_i) begin
          run_end_o <= 1'b1;
          active_q  <= 1'b0;
        end else begin
          exec_cycles_o <= exec_cycles_o + 1'b1;
          // last count stops the run and holds the limit
          if (exec_cycles_o == TIMEOUT_CYCLES - 1'b1) begin
            run_end_o   <= 1'b1;
            timed_out_o <= 1'b1;
            active_q    <= 1'b0;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- source/sdt_result_check.sv
// result checker
// latches the UUT result and status byte,
// counts tests and failing tests

`timescale 1ns/1ps
`default_nettype none

module sdt_result_check
  import sdt_test_pkg::*;
(
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 start_i,
  input  wire                 check_en_i,
  input  wire  [RESULT_W-1:0] uut_result_i,
  input  wire  [RESULT_W-1:0] expected_i,
  input  wire                 timed_out_i,
  output logic [RESULT_W-1:0] result_o,
  output logic [STATUS_W-1:0] status_o,
  output logic [COUNT_W-1:0]  test_count_o,
  output logic [COUNT_W-1:0]  error_count_o
);

  logic [STATUS_W-1:0] status_d;

  always_comb begin
    status_d = '0;
    status_d[STATUS_MISMATCH_BIT] = (uut_result_i != expected_i);
    status_d[STATUS_TIMEOUT_BIT]  = timed_out_i;
  end

  always_ff @(posedge clk) begin
    if (check_en_i) begin
      result_o <= uut_result_i;
      status_o <= status_d;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || start_i) begin
      test_count_o  <= '0;
      error_count_o <= '0;
    end else if (check_en_i) begin
      test_count_o <= test_count_o + 1'b1;
      if (|status_d) begin
        error_count_o <= error_count_o + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/sdt_result_writer.sv
// result block writer
// streams record, UUT result, cycle count, status
// and zero fill over valid/ready

`timescale 1ns/1ps
`default_nettype none

module sdt_result_writer
  import sdt_storage_pkg::*;
  import sdt_test_pkg::*;
(
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 write_start_i,
  input  wire  test_record_u  record_i,
  input  wire  [RESULT_W-1:0] result_i,
  input  wire  [CYCLES_W-1:0] exec_cycles_i,
  input  wire  [STATUS_W-1:0] status_i,
  input  wire                 wr_ready_i,
  output logic [7:0]          wr_data_o,
  output logic                wr_valid_o,
  output logic                write_done_o
);

  logic [BYTE_CNT_W-1:0] byte_cnt;

  // msb first within a 32-bit field
  function automatic logic [7:0] word_byte(input logic [31:0] word, input logic [1:0] idx);
    return word[8 * (3 - idx) +: 8];
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_valid_o   <= 1'b0;
      write_done_o <= 1'b0;
      byte_cnt     <= '0;
    end else begin
      write_done_o <= 1'b0;
      if (write_start_i) begin
        wr_valid_o <= 1'b1;
        byte_cnt   <= '0;
      end else if (wr_valid_o && wr_ready_i) begin
        byte_cnt <= byte_cnt + 1'b1;
        if (byte_cnt == BYTE_CNT_W'(BLOCK_BYTES - 1)) begin
          wr_valid_o   <= 1'b0;
          write_done_o <= 1'b1;
        end
      end
    end
  end

  // counter only moves on a handshake, so the byte holds while stalled
  always_comb begin
    wr_data_o = 8'h00;
    if (byte_cnt < RECORD_BYTES) begin
      wr_data_o = record_i.bytes[byte_cnt[RECORD_IDX_W-1:0]];
    end else if (byte_cnt >= RES_RESULT_OFS && byte_cnt < RES_CYCLES_OFS) begin
      wr_data_o = word_byte(result_i, 2'(byte_cnt - RES_RESULT_OFS));
    end else if (byte_cnt >= RES_CYCLES_OFS && byte_cnt < RES_STATUS_OFS) begin
      wr_data_o = word_byte(exec_cycles_i, 2'(byte_cnt - RES_CYCLES_OFS));
    end else if (byte_cnt == RES_STATUS_OFS) begin
      wr_data_o = status_i;
    end
  end

endmodule

`default_nettype wire

//--- source/sdt_top.sv
// autotest sequencer top level
// control FSM, record loader, execution timer,
// result checker and result block writer

`timescale 1ns/1ps
`default_nettype none

module sdt_top
  import sdt_storage_pkg::*;
  import sdt_test_pkg::*;
(
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     start_i,
  output logic                    rd_req_o,
  input  wire                     rd_gnt_i,
  input  wire  [7:0]              rd_data_i,
  input  wire                     rd_valid_i,
  output logic                    rd_ready_o,
  output logic                    wr_req_o,
  input  wire                     wr_gnt_i,
  output logic [7:0]              wr_data_o,
  output logic                    wr_valid_o,
  input  wire                     wr_ready_i,
  output logic [BLOCK_ADDR_W-1:0] blk_addr_o,
  output logic                    uut_rst_o,
  input  wire                     uut_done_i,
  input  wire  [RESULT_W-1:0]     uut_result_i,
  output logic [OPERAND_W-1:0]    operand_a_o,
  output logic [OPERAND_W-1:0]    operand_b_o,
  output logic                    busy_o,
  output logic                    run_done_o,
  output logic [COUNT_W-1:0]      test_count_o,
  output logic [COUNT_W-1:0]      error_count_o
);

  logic                load_start;
  logic                load_done;
  test_record_u        record;
  logic                run_start;
  logic                run_end;
  logic [CYCLES_W-1:0] exec_cycles;
  logic                timed_out;
  logic                check_en;
  logic [RESULT_W-1:0] result;
  logic [STATUS_W-1:0] status;
  logic                write_start;
  logic                write_done;

  // operands go straight from the loaded record to the UUT
  assign operand_a_o = record.fields.operand_a;
  assign operand_b_o = record.fields.operand_b;

  sdt_control u_control (
    .clk(clk), .rst(rst), .start_i(start_i),
    .rd_gnt_i(rd_gnt_i), .wr_gnt_i(wr_gnt_i),
    .load_done_i(load_done), .record_i(record), .run_end_i(run_end),
    .write_done_i(write_done), .rd_req_o(rd_req_o), .wr_req_o(wr_req_o),
    .blk_addr_o(blk_addr_o), .uut_rst_o(uut_rst_o), .load_start_o(load_start),
    .run_start_o(run_start), .check_en_o(check_en), .write_start_o(write_start),
    .busy_o(busy_o), .run_done_o(run_done_o)
  );

  sdt_record_loader u_loader (
    .clk(clk), .rst(rst), .load_start_i(load_start),
    .rd_data_i(rd_data_i), .rd_valid_i(rd_valid_i), .rd_ready_o(rd_ready_o),
    .load_done_o(load_done), .record_o(record)
  );

  sdt_exec_timer u_timer (
    .clk(clk), .rst(rst), .run_start_i(run_start), .uut_running_i(~uut_rst_o),
    .uut_done_i(uut_done_i), .run_end_o(run_end), .exec_cycles_o(exec_cycles),
    .timed_out_o(timed_out)
  );

  sdt_result_check u_check (
    .clk(clk), .rst(rst), .start_i(start_i), .check_en_i(check_en),
    .uut_result_i(uut_result_i), .expected_i(record.fields.expected),
    .timed_out_i(timed_out), .result_o(result), .status_o(status),
    .test_count_o(test_count_o), .error_count_o(error_count_o)
  );

  sdt_result_writer u_writer (
    .clk(clk), .rst(rst), .write_start_i(write_start), .record_i(record),
    .result_i(result), .exec_cycles_i(exec_cycles), .status_i(status),
    .wr_ready_i(wr_ready_i), .wr_data_o(wr_data_o), .wr_valid_o(wr_valid_o),
    .write_done_o(write_done)
  );

endmodule

`default_nettype wire

//--- verif/sdt_properties.sv
// bound checks on the autotest sequencer top level
// block requests held until grant, write data held under stall,
// UUT kept in reset while a block request is pending

`timescale 1ns/1ps
`default_nettype none

module sdt_properties
  import sdt_storage_pkg::*;
(
  input wire                    clk,
  input wire                    rst,
  input wire                    rd_req_i,
  input wire                    rd_gnt_i,
  input wire                    wr_req_i,
  input wire                    wr_gnt_i,
  input wire [BLOCK_ADDR_W-1:0] blk_addr_i,
  input wire                    wr_valid_i,
  input wire                    wr_ready_i,
  input wire [7:0]              wr_data_i,
  input wire                    uut_rst_i
);

  rd_req_held: assert property (@(posedge clk) disable iff (rst)
    rd_req_i && !rd_gnt_i |=> rd_req_i && $stable(blk_addr_i))
    else $error("read request or block address changed before grant");

  wr_req_held: assert property (@(posedge clk) disable iff (rst)
    wr_req_i && !wr_gnt_i |=> wr_req_i && $stable(blk_addr_i))
    else $error("write request or block address changed before grant");

  // stalled byte stays on the bus
  wr_data_held: assert property (@(posedge clk) disable iff (rst)
    wr_valid_i && !wr_ready_i |=> wr_valid_i && $stable(wr_data_i))
    else $error("write byte changed or dropped while stalled");

  uut_rst_on_req: assert property (@(posedge clk) disable iff (rst)
    rd_req_i || wr_req_i |-> uut_rst_i)
    else $error("UUT out of reset while a block request is pending");

endmodule

bind sdt_top sdt_properties u_properties (
  .clk(clk), .rst(rst), .rd_req_i(rd_req_o), .rd_gnt_i(rd_gnt_i),
  .wr_req_i(wr_req_o), .wr_gnt_i(wr_gnt_i), .blk_addr_i(blk_addr_o),
  .wr_valid_i(wr_valid_o), .wr_ready_i(wr_ready_i), .wr_data_i(wr_data_o),
  .uut_rst_i(uut_rst_o)
);

`default_nettype wire

//--- verif/sdt_tb.sv
// testbench for the autotest sequencer
// storage host model with random grants, valid gaps and ready stalls
// UUT model and expected result blocks built from the test vector file
// final counter checks and a watchdog

`timescale 1ns/1ps
`default_nettype none

module sdt_tb
  import sdt_storage_pkg::*;
  import sdt_test_pkg::*;
();

  localparam int unsigned MAX_VECTORS       = 32;
  localparam int unsigned CYCLES_PER_VECTOR = 2000;
  localparam logic [31:0] SEED              = 32'hbfc7;
  localparam logic [31:0] UUT_IDLE_RESULT   = 32'h0;

  logic                    clk;
  logic                    rst;
  logic                    start_i;
  logic                    rd_req_o;
  logic                    rd_gnt_i;
  logic [7:0]              rd_data_i;
  logic                    rd_valid_i;
  logic                    rd_ready_o;
  logic                    wr_req_o;
  logic                    wr_gnt_i;
  logic [7:0]              wr_data_o;
  logic                    wr_valid_o;
  logic                    wr_ready_i;
  logic [BLOCK_ADDR_W-1:0] blk_addr_o;
  logic                    uut_rst_o;
  logic                    uut_done_i;
  logic [RESULT_W-1:0]     uut_result_i;
  logic [OPERAND_W-1:0]    operand_a_o;
  logic [OPERAND_W-1:0]    operand_b_o;
  logic                    busy_o;
  logic                    run_done_o;
  logic [COUNT_W-1:0]      test_count_o;
  logic [COUNT_W-1:0]      error_count_o;

  // six words per vector as laid out in the data file
  logic [31:0] vec_mem [0:255];
  int          n_vectors;
  int          reads_seen;
  int          writes_seen;
  int          rd_fails;
  int          wr_fails;
  int          uut_fails;
  int          main_fails;

  sdt_top u_dut (
    .clk(clk), .rst(rst), .start_i(start_i),
    .rd_req_o(rd_req_o), .rd_gnt_i(rd_gnt_i), .rd_data_i(rd_data_i),
    .rd_valid_i(rd_valid_i), .rd_ready_o(rd_ready_o),
    .wr_req_o(wr_req_o), .wr_gnt_i(wr_gnt_i), .wr_data_o(wr_data_o),
    .wr_valid_o(wr_valid_o), .wr_ready_i(wr_ready_i), .blk_addr_o(blk_addr_o),
    .uut_rst_o(uut_rst_o), .uut_done_i(uut_done_i), .uut_result_i(uut_result_i),
    .operand_a_o(operand_a_o), .operand_b_o(operand_b_o),
    .busy_o(busy_o), .run_done_o(run_done_o),
    .test_count_o(test_count_o), .error_count_o(error_count_o)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // column order is signature, operand_a, operand_b, expected, uut_result, latency
  function automatic logic [31:0] vec_field(input int idx, input int col);
    return vec_mem[8'(6 * idx + col)];
  endfunction

  function automatic logic [7:0] msb_byte(input logic [31:0] word, input int pos);
    return 8'(word >> (8 * (3 - pos)));
  endfunction

  function automatic logic expected_timeout(input int idx);
    return vec_field(idx, 5) >= TIMEOUT_CYCLES;
  endfunction

  // a UUT still running past the timeout edge leaves the idle value on its bus
  // done on the timeout edge itself still reaches the checker
  function automatic logic [31:0] expected_result(input int idx);
    return (vec_field(idx, 5) > TIMEOUT_CYCLES) ? UUT_IDLE_RESULT : vec_field(idx, 4);
  endfunction

  function automatic logic [7:0] expected_status(input int idx);
    logic [7:0] st;
    st = 8'h00;
    st[STATUS_MISMATCH_BIT] = (expected_result(idx) != vec_field(idx, 3));
    st[STATUS_TIMEOUT_BIT]  = expected_timeout(idx);
    return st;
  endfunction

  function automatic logic [7:0] expected_write_byte(input int idx, input int pos);
    logic [31:0] cycles;
    cycles = expected_timeout(idx) ? TIMEOUT_CYCLES : vec_field(idx, 5);
    if (pos < RECORD_BYTES) begin
      return msb_byte(vec_field(idx, pos / 4), pos % 4);
    end else if (pos < RES_CYCLES_OFS) begin
      return msb_byte(expected_result(idx), pos - RES_RESULT_OFS);
    end else if (pos < RES_STATUS_OFS) begin
      return msb_byte(cycles, pos - RES_CYCLES_OFS);
    end else if (pos == RES_STATUS_OFS) begin
      return expected_status(idx);
    end
    return 8'h00;
  endfunction

  // record first and random filler after it
  function automatic logic [7:0] read_byte(input int idx, input int pos, input logic [31:0] rnd);
    if (pos < RECORD_BYTES) begin
      return msb_byte(vec_field(idx, pos / 4), pos % 4);
    end
    return rnd[7:0];
  endfunction

  function automatic bit check_value(input string what, input logic [31:0] got,
                                     input logic [31:0] exp);
    bit ok;
    ok = 1'b1;
    assert (got === exp) else begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
      ok = 1'b0;
    end
    return ok;
  endfunction

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    int i;
    int exp_errors;
    int total;
    rst     <= 1'b1;
    start_i <= 1'b0;
    main_fails = 0;
    for (i = 0; i < 256; i++) begin
      vec_mem[8'(i)] = 32'h0;
    end
    $readmemh("verif/sdt_testdata.txt", vec_mem);
    n_vectors = 0;
    while (n_vectors < MAX_VECTORS && vec_field(n_vectors, 0) == SIGNATURE) begin
      n_vectors++;
    end
    assert (n_vectors > 0 && n_vectors < MAX_VECTORS) else begin
      $display("test data file holds no valid vector or lacks the closing bad line");
      main_fails++;
    end
    exp_errors = 0;
    for (i = 0; i < n_vectors; i++) begin
      if (expected_status(i) != 8'h00) begin
        exp_errors++;
      end
    end

    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    if (!check_value("control flags after reset",
        32'({rd_req_o, wr_req_o, wr_valid_o, rd_ready_o, busy_o, run_done_o, uut_rst_o}),
        32'h1)) main_fails++;
    if (!check_value("test_count_o after reset", test_count_o, 32'h0)) main_fails++;
    if (!check_value("error_count_o after reset", error_count_o, 32'h0)) main_fails++;

    start_i <= 1'b1;
    @(posedge clk);
    start_i <= 1'b0;
    @(posedge clk);
    if (!check_value("rd_req_o one cycle after start", 32'(rd_req_o), 32'h1)) main_fails++;

    while (!run_done_o) @(posedge clk);
    if (!check_value("test_count_o", test_count_o, 32'(n_vectors))) main_fails++;
    if (!check_value("error_count_o", error_count_o, 32'(exp_errors))) main_fails++;
    @(posedge clk);
    if (!check_value("run_done_o and busy_o after the end",
        32'({run_done_o, busy_o}), 32'h0)) main_fails++;
    // the bad block must not be written back
    repeat (20) begin
      @(posedge clk);
      assert (!wr_req_o) else begin
        $display("write requested for the bad signature block at %0t", $time);
        main_fails++;
      end
    end
    if (!check_value("result blocks written", 32'(writes_seen), 32'(n_vectors))) main_fails++;
    if (!check_value("blocks read", 32'(reads_seen), 32'(n_vectors + 1))) main_fails++;

    total = rd_fails + wr_fails + uut_fails + main_fails;
    $display("%0d tests run, %0d checks failed", n_vectors, total);
    if (total == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // read side of the storage host
  initial begin
    logic [31:0] rnd;
    int pos;
    rnd = SEED;
    rd_fails = 0;
    reads_seen = 0;
    rd_gnt_i   <= 1'b0;
    rd_valid_i <= 1'b0;
    rd_data_i  <= 8'h00;
    forever begin
      @(posedge clk);
      if (!rst && rd_req_o) begin
        if (!check_value("read block address", blk_addr_o,
            START_BLOCK + 32'(reads_seen))) rd_fails++;
        assert (reads_seen <= n_vectors) else begin
          $display("read requested past the closing test data line at %0t", $time);
          rd_fails++;
        end
        reads_seen++;
        rnd = xorshift32(rnd);
        repeat (rnd[1:0]) @(posedge clk);
        rd_gnt_i <= 1'b1;
        @(posedge clk);
        rd_gnt_i <= 1'b0;
        for (pos = 0; pos < BLOCK_BYTES; pos++) begin
          rnd = xorshift32(rnd);
          if (rnd[9:8] == 2'b00) begin
            rd_valid_i <= 1'b0;
            repeat (rnd[11:10] + 1) @(posedge clk);
          end
          rd_valid_i <= 1'b1;
          rd_data_i  <= read_byte(reads_seen - 1, pos, rnd);
          @(posedge clk);
          while (!rd_ready_o) @(posedge clk);
        end
        rd_valid_i <= 1'b0;
      end
    end
  end

  // write side of the storage host
  initial begin
    logic [31:0] rnd;
    int pos;
    int idx;
    int bad;
    rnd = SEED;
    wr_fails = 0;
    writes_seen = 0;
    wr_gnt_i   <= 1'b0;
    wr_ready_i <= 1'b0;
    forever begin
      @(posedge clk);
      if (!rst && wr_req_o) begin
        idx = writes_seen;
        bad = 0;
        if (!check_value("write block address", blk_addr_o,
            START_BLOCK + 32'(idx))) bad++;
        assert (reads_seen == idx + 1) else begin
          $display("write request at %0t does not follow the read of its block", $time);
          bad++;
        end
        rnd = xorshift32(rnd);
        repeat (rnd[3:2]) @(posedge clk);
        wr_gnt_i <= 1'b1;
        @(posedge clk);
        wr_gnt_i <= 1'b0;
        pos = 0;
        while (pos < BLOCK_BYTES) begin
          rnd = xorshift32(rnd);
          wr_ready_i <= (rnd[1:0] != 2'b00);
          @(posedge clk);
          if (wr_valid_o && wr_ready_i) begin
            if (!check_value($sformatf("byte %0d of result block %0d", pos, idx),
                32'(wr_data_o), 32'(expected_write_byte(idx, pos)))) bad++;
            pos++;
          end
        end
        wr_ready_i <= 1'b0;
        @(posedge clk);
        assert (!wr_valid_o) else begin
          $display("writer still offers data after the last byte of block %0d", idx);
          bad++;
        end
        wr_fails += bad;
        writes_seen++;
        $display("test %0d: status %02h, %0d failed checks", idx, expected_status(idx), bad);
      end
    end
  end

  // UUT model holding done low for latency run edges
  initial begin
    int run_edges;
    int idx;
    uut_fails = 0;
    run_edges = 0;
    uut_done_i   <= 1'b0;
    uut_result_i <= UUT_IDLE_RESULT;
    forever begin
      @(posedge clk);
      if (rst || uut_rst_o) begin
        run_edges = 0;
        uut_done_i <= 1'b0;
      end else begin
        idx = reads_seen - 1;
        if (run_edges == 0) begin
          if (!check_value("operand_a_o", operand_a_o, vec_field(idx, 1))) uut_fails++;
          if (!check_value("operand_b_o", operand_b_o, vec_field(idx, 2))) uut_fails++;
          uut_result_i <= UUT_IDLE_RESULT;
        end
        run_edges++;
        if (32'(run_edges) >= vec_field(idx, 5)) begin
          uut_done_i   <= 1'b1;
          uut_result_i <= vec_field(idx, 4);
        end
      end
    end
  end

  initial begin
    int limit;
    @(posedge clk);
    limit = (n_vectors + 1) * CYCLES_PER_VECTOR;
    repeat (limit) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", limit);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/sdt_testdata.txt
// signature operand_a operand_b expected uut_result latency, all hex
// the last line has a bad signature and ends the run
AABBCCDD 00000003 00000004 00000007 00000007 00000001
AABBCCDD 12345678 11111111 23456789 23456789 00000005
AABBCCDD FFFFFFFF 00000001 00000000 00000000 00000010
AABBCCDD 0000A5A5 00005A5A 0000FFFF 0000FFF0 00000003
AABBCCDD 80000000 80000000 00000000 00000000 000000FA
AABBCCDD DEADBEEF 01020304 DFAFC1F3 DFAFC1F3 00000040
AABBCCDD 00000100 00000200 00000300 00000301 000000C7
AABBCCDD 7FFFFFFF 00000001 80000000 80000000 00000002
AABBCCDD CAFEF00D 00000000 CAFEF00D CAFEF00D 000000C8
AABBCCDE 00000000 00000000 00000000 00000000 00000001

//--- sd_autotest.f
source/sdt_storage_pkg.sv
source/sdt_test_pkg.sv
source/sdt_control.sv
source/sdt_record_loader.sv
source/sdt_exec_timer.sv
source/sdt_result_check.sv
source/sdt_result_writer.sv
source/sdt_top.sv
verif/sdt_properties.sv
verif/sdt_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the autotest sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
    --top-module sdt_tb -Mdir obj_dir -f sd_autotest.f; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/Vsdt_tb > sim.log 2>&1; then
  cat sim.log
  echo "simulation exited with an error status"
  exit 1
fi
cat sim.log

if grep -q "^No errors$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
